// ==== hw/jump_ctrl_pkg.sv ====
`default_nettype none

package jump_ctrl_pkg;

	// Address and instruction words
	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;

	// RV32 opcode field
	typedef logic [6:0] opcode_t;

	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_JALR   = 7'b1100111;

	// Register numbers, x1 and x5 are the link registers
	typedef logic [4:0] reg_idx_t;

	localparam reg_idx_t REG_ZERO = 5'd0;
	localparam reg_idx_t REG_RA   = 5'd1;
	localparam reg_idx_t REG_T0   = 5'd5;

	typedef logic [2:0] ras_ptr_t; // Eight entry RAS

	// Two-bit saturating counter
	typedef logic [1:0] ctr2_t;

	localparam ctr2_t CTR_WEAK_NT = 2'd1;

	typedef logic [4:0] slot_vec_t; // One bit per fetch slot

endpackage

`default_nettype wire

// ==== hw/fetch_slot_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_slot_decoder (
	input  logic                      base_valid_i,
	input  jump_ctrl_pkg::addr_t      pc_0_i,
	input  jump_ctrl_pkg::addr_t      pc_1_i,
	input  jump_ctrl_pkg::addr_t      pc_2_i,
	input  jump_ctrl_pkg::addr_t      pc_3_i,
	input  jump_ctrl_pkg::addr_t      pc_4_i,
	input  jump_ctrl_pkg::inst_t      inst_0_i,
	input  jump_ctrl_pkg::inst_t      inst_1_i,
	input  jump_ctrl_pkg::inst_t      inst_2_i,
	input  jump_ctrl_pkg::inst_t      inst_3_i,
	input  jump_ctrl_pkg::inst_t      inst_4_i,
	input  jump_ctrl_pkg::slot_vec_t  taken_slots_i,
	output logic                      jump_0_o,
	output logic                      jump_1_o,
	output logic                      jump_2_o,
	output logic                      jump_3_o,
	output logic                      jump_4_o,
	output logic                      jalr_0_o,
	output logic                      jalr_1_o,
	output logic                      jalr_2_o,
	output logic                      jalr_3_o,
	output logic                      jalr_4_o,
	output jump_ctrl_pkg::slot_vec_t  branch_slots_o,
	output jump_ctrl_pkg::slot_vec_t  jalr_slots_o,
	output jump_ctrl_pkg::slot_vec_t  call_slots_o,
	output jump_ctrl_pkg::slot_vec_t  return_slots_o,
	output jump_ctrl_pkg::addr_t      link_addr_0_o,
	output jump_ctrl_pkg::addr_t      link_addr_1_o,
	output jump_ctrl_pkg::addr_t      link_addr_2_o,
	output jump_ctrl_pkg::addr_t      link_addr_3_o,
	output jump_ctrl_pkg::addr_t      link_addr_4_o
);

	jump_ctrl_pkg::addr_t      pc_a [5];
	jump_ctrl_pkg::inst_t      inst_a [5];
	jump_ctrl_pkg::addr_t      link_a [5];
	jump_ctrl_pkg::slot_vec_t  jump_v;
	jump_ctrl_pkg::slot_vec_t  jalr_v;
	logic [4:0]                active; // Slot k still counts

	assign pc_a[0] = pc_0_i;
	assign pc_a[1] = pc_1_i;
	assign pc_a[2] = pc_2_i;
	assign pc_a[3] = pc_3_i;
	assign pc_a[4] = pc_4_i;
	assign inst_a[0] = inst_0_i;
	assign inst_a[1] = inst_1_i;
	assign inst_a[2] = inst_2_i;
	assign inst_a[3] = inst_3_i;
	assign inst_a[4] = inst_4_i;

	assign active[0] = base_valid_i; // Slot 0 only needs a valid group

	//////////////////////////////////////////////////
	// Per-slot decode and block chain
	//////////////////////////////////////////////////
	for (genvar k = 0; k < 5; k++) begin : g_slot
		jump_ctrl_pkg::opcode_t  opc;
		jump_ctrl_pkg::reg_idx_t rd;
		jump_ctrl_pkg::reg_idx_t rs1;
		logic                    is_jal;
		logic                    is_br;
		logic                    is_jalr;
		logic                    link_rd;
		logic                    link_rs1;

		assign opc = inst_a[k][6:0];
		assign rd  = inst_a[k][11:7];
		assign rs1 = inst_a[k][19:15];

		assign is_jal  = (opc == jump_ctrl_pkg::OPC_JAL);
		assign is_br   = (opc == jump_ctrl_pkg::OPC_BRANCH);
		assign is_jalr = (opc == jump_ctrl_pkg::OPC_JALR);

		assign link_rd  = (rd == jump_ctrl_pkg::REG_RA) || (rd == jump_ctrl_pkg::REG_T0);
		assign link_rs1 = (rs1 == jump_ctrl_pkg::REG_RA) || (rs1 == jump_ctrl_pkg::REG_T0);

		assign jump_v[k] = active[k] & (is_jal | (is_br & taken_slots_i[k]));
		assign jalr_v[k] = active[k] & is_jalr;

		// Redirect in this slot kills all later slots
		if (k < 4) begin : g_next
			assign active[k+1] = active[k] & ~jump_v[k] & ~jalr_v[k];
		end

		assign branch_slots_o[k] = active[k] & is_br;
		assign call_slots_o[k]   = active[k] & (is_jal | is_jalr) & link_rd;
		assign return_slots_o[k] = jalr_v[k] & link_rs1 & (rd == jump_ctrl_pkg::REG_ZERO);
		assign link_a[k]         = pc_a[k] + 32'd4;
	end

	assign jalr_slots_o = jalr_v;

	assign jump_0_o = jump_v[0];
	assign jump_1_o = jump_v[1];
	assign jump_2_o = jump_v[2];
	assign jump_3_o = jump_v[3];
	assign jump_4_o = jump_v[4];
	assign jalr_0_o = jalr_v[0];
	assign jalr_1_o = jalr_v[1];
	assign jalr_2_o = jalr_v[2];
	assign jalr_3_o = jalr_v[3];
	assign jalr_4_o = jalr_v[4];

	assign link_addr_0_o = link_a[0];
	assign link_addr_1_o = link_a[1];
	assign link_addr_2_o = link_a[2];
	assign link_addr_3_o = link_a[3];
	assign link_addr_4_o = link_a[4];

endmodule

`default_nettype wire

// ==== hw/tournament_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tournament_predictor #(
	parameter int ENTRIES     = 32,
	parameter int INDEX_WIDTH = $clog2(ENTRIES)
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      base_valid_i,
	input  jump_ctrl_pkg::addr_t      pc_0_i,
	input  jump_ctrl_pkg::addr_t      pc_1_i,
	input  jump_ctrl_pkg::addr_t      pc_2_i,
	input  jump_ctrl_pkg::addr_t      pc_3_i,
	input  jump_ctrl_pkg::addr_t      pc_4_i,
	input  jump_ctrl_pkg::slot_vec_t  branch_slots_i,
	input  logic                      upd_valid_i,
	input  jump_ctrl_pkg::addr_t      upd_pc_i,
	input  logic                      upd_taken_i,
	input  logic                      upd_mispredict_i,
	input  logic [INDEX_WIDTH-1:0]    upd_history_i,
	output jump_ctrl_pkg::slot_vec_t  taken_slots_o,
	output logic [INDEX_WIDTH-1:0]    global_history_0_o,
	output logic [INDEX_WIDTH-1:0]    global_history_1_o,
	output logic [INDEX_WIDTH-1:0]    global_history_2_o,
	output logic [INDEX_WIDTH-1:0]    global_history_3_o,
	output logic [INDEX_WIDTH-1:0]    global_history_4_o
);

	jump_ctrl_pkg::ctr2_t bim_tbl [ENTRIES];
	jump_ctrl_pkg::ctr2_t gsh_tbl [ENTRIES];
	jump_ctrl_pkg::ctr2_t cho_tbl [ENTRIES]; // Counter >= 2 picks gshare

	logic [INDEX_WIDTH-1:0] ghr;
	logic [INDEX_WIDTH-1:0] hist [6]; // History seen by each slot, hist[5] is next ghr
	jump_ctrl_pkg::addr_t   pc_a [5];

	logic [INDEX_WIDTH-1:0] upd_bim_idx;
	logic [INDEX_WIDTH-1:0] upd_gsh_idx;
	logic                   upd_bim_ok;
	logic                   upd_gsh_ok;

	function automatic jump_ctrl_pkg::ctr2_t ctr_step(input jump_ctrl_pkg::ctr2_t ctr,
			input logic up);
		ctr_step = ctr;
		if (up && ctr != 2'b11)
			ctr_step = ctr + 2'd1;
		else if (!up && ctr != 2'b00)
			ctr_step = ctr - 2'd1;
	endfunction

	assign pc_a[0] = pc_0_i;
	assign pc_a[1] = pc_1_i;
	assign pc_a[2] = pc_2_i;
	assign pc_a[3] = pc_3_i;
	assign pc_a[4] = pc_4_i;

	//////////////////////////////////////////////////
	// Lookup with in-group history chain
	//////////////////////////////////////////////////
	assign hist[0] = ghr;

	for (genvar k = 0; k < 5; k++) begin : g_slot
		logic [INDEX_WIDTH-1:0] bim_idx;
		logic [INDEX_WIDTH-1:0] gsh_idx;
		logic                   use_gsh;

		assign bim_idx = pc_a[k][INDEX_WIDTH+1:2];
		assign gsh_idx = bim_idx ^ hist[k];
		assign use_gsh = cho_tbl[bim_idx][1];

		assign taken_slots_o[k] = use_gsh ? gsh_tbl[gsh_idx][1] : bim_tbl[bim_idx][1];

		// Only active branches shift their guess in
		assign hist[k+1] = branch_slots_i[k] ?
				{hist[k][INDEX_WIDTH-2:0], taken_slots_o[k]} : hist[k];
	end

	assign global_history_0_o = hist[0];
	assign global_history_1_o = hist[1];
	assign global_history_2_o = hist[2];
	assign global_history_3_o = hist[3];
	assign global_history_4_o = hist[4];

	//////////////////////////////////////////////////
	// Training
	//////////////////////////////////////////////////
	assign upd_bim_idx = upd_pc_i[INDEX_WIDTH+1:2];
	assign upd_gsh_idx = upd_bim_idx ^ upd_history_i;
	assign upd_bim_ok  = (bim_tbl[upd_bim_idx][1] == upd_taken_i);
	assign upd_gsh_ok  = (gsh_tbl[upd_gsh_idx][1] == upd_taken_i);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < ENTRIES; i++) begin
				bim_tbl[i] <= jump_ctrl_pkg::CTR_WEAK_NT;
				gsh_tbl[i] <= jump_ctrl_pkg::CTR_WEAK_NT;
				cho_tbl[i] <= jump_ctrl_pkg::CTR_WEAK_NT; // Weakly bimodal
			end
		end else if (upd_valid_i) begin
			bim_tbl[upd_bim_idx] <= ctr_step(bim_tbl[upd_bim_idx], upd_taken_i);
			gsh_tbl[upd_gsh_idx] <= ctr_step(gsh_tbl[upd_gsh_idx], upd_taken_i);
			if (upd_bim_ok != upd_gsh_ok)
				cho_tbl[upd_bim_idx] <= ctr_step(cho_tbl[upd_bim_idx], upd_gsh_ok);
		end
	end

	// Repair beats the speculative shift
	always_ff @(posedge clk) begin
		if (!rst_n_i)
			ghr <= '0;
		else if (upd_valid_i && upd_mispredict_i)
			ghr <= {upd_history_i[INDEX_WIDTH-2:0], upd_taken_i};
		else if (base_valid_i)
			ghr <= hist[5];
	end

endmodule

`default_nettype wire

// ==== hw/jalr_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module jalr_predictor #(
	parameter int TARGET_ENTRIES = 16
) (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic                      base_valid_i,
	input  jump_ctrl_pkg::addr_t      pc_0_i,
	input  jump_ctrl_pkg::addr_t      pc_1_i,
	input  jump_ctrl_pkg::addr_t      pc_2_i,
	input  jump_ctrl_pkg::addr_t      pc_3_i,
	input  jump_ctrl_pkg::addr_t      pc_4_i,
	input  jump_ctrl_pkg::slot_vec_t  jalr_slots_i,
	input  jump_ctrl_pkg::slot_vec_t  call_slots_i,
	input  jump_ctrl_pkg::slot_vec_t  return_slots_i,
	input  jump_ctrl_pkg::addr_t      link_addr_0_i,
	input  jump_ctrl_pkg::addr_t      link_addr_1_i,
	input  jump_ctrl_pkg::addr_t      link_addr_2_i,
	input  jump_ctrl_pkg::addr_t      link_addr_3_i,
	input  jump_ctrl_pkg::addr_t      link_addr_4_i,
	input  logic                      jalr_upd_valid_i,
	input  jump_ctrl_pkg::addr_t      jalr_upd_pc_i,
	input  jump_ctrl_pkg::addr_t      jalr_upd_target_i,
	input  logic                      ras_restore_en_i,
	input  jump_ctrl_pkg::ras_ptr_t   ras_restore_tos_i,
	output logic                      jalr_pred_valid_o,
	output jump_ctrl_pkg::addr_t      jalr_pred_target_o,
	output jump_ctrl_pkg::ras_ptr_t   ras_tos_checkpoint_o
);

	localparam int TGT_IDX_W = $clog2(TARGET_ENTRIES);

	jump_ctrl_pkg::addr_t    ras [8];
	jump_ctrl_pkg::ras_ptr_t tos;
	jump_ctrl_pkg::addr_t    tgt_tbl [TARGET_ENTRIES]; // Target cache payload
	logic [TARGET_ENTRIES-1:0] tgt_vld;

	jump_ctrl_pkg::addr_t pc_a [5];
	jump_ctrl_pkg::addr_t link_a [5];
	jump_ctrl_pkg::addr_t sel_pc;
	jump_ctrl_pkg::addr_t push_addr;
	logic                 sel_ret;
	logic [TGT_IDX_W-1:0] sel_idx;
	logic [TGT_IDX_W-1:0] upd_idx;

	assign pc_a[0] = pc_0_i;
	assign pc_a[1] = pc_1_i;
	assign pc_a[2] = pc_2_i;
	assign pc_a[3] = pc_3_i;
	assign pc_a[4] = pc_4_i;
	assign link_a[0] = link_addr_0_i;
	assign link_a[1] = link_addr_1_i;
	assign link_a[2] = link_addr_2_i;
	assign link_a[3] = link_addr_3_i;
	assign link_a[4] = link_addr_4_i;

	// Lowest active JALR and lowest call win
	always_comb begin
		sel_pc    = pc_a[0];
		sel_ret   = 1'b0;
		push_addr = link_a[0];
		for (int k = 4; k >= 0; k--) begin
			if (jalr_slots_i[k]) begin
				sel_pc  = pc_a[k];
				sel_ret = return_slots_i[k];
			end
			if (call_slots_i[k])
				push_addr = link_a[k];
		end
	end

	//////////////////////////////////////////////////
	// Prediction
	//////////////////////////////////////////////////
	assign sel_idx = sel_pc[TGT_IDX_W+1:2];
	assign upd_idx = jalr_upd_pc_i[TGT_IDX_W+1:2];

	assign jalr_pred_valid_o  = (|jalr_slots_i) & (sel_ret | tgt_vld[sel_idx]);
	assign jalr_pred_target_o = sel_ret ? ras[tos] : tgt_tbl[sel_idx];

	assign ras_tos_checkpoint_o = tos;

	// RAS, restore first, then pop, then push
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			tos <= '0;
			for (int i = 0; i < 8; i++)
				ras[i] <= '0;
		end else if (ras_restore_en_i) begin
			tos <= ras_restore_tos_i;
		end else if (base_valid_i && |return_slots_i) begin
			tos <= tos - 3'd1;
		end else if (base_valid_i && |call_slots_i) begin
			ras[tos + 3'd1] <= push_addr;
			tos             <= tos + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			tgt_vld <= '0;
		else if (jalr_upd_valid_i)
			tgt_vld[upd_idx] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (jalr_upd_valid_i)
			tgt_tbl[upd_idx] <= jalr_upd_target_i; // Aliasing PCs overwrite
	end

endmodule

`default_nettype wire

// ==== hw/jump_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module jump_controller #(
	parameter int ENTRIES        = 32,
	parameter int TARGET_ENTRIES = 16
) (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic                     base_valid_i,
	input  jump_ctrl_pkg::addr_t     pc_0_i,
	input  jump_ctrl_pkg::addr_t     pc_1_i,
	input  jump_ctrl_pkg::addr_t     pc_2_i,
	input  jump_ctrl_pkg::addr_t     pc_3_i,
	input  jump_ctrl_pkg::addr_t     pc_4_i,
	input  jump_ctrl_pkg::inst_t     inst_0_i,
	input  jump_ctrl_pkg::inst_t     inst_1_i,
	input  jump_ctrl_pkg::inst_t     inst_2_i,
	input  jump_ctrl_pkg::inst_t     inst_3_i,
	input  jump_ctrl_pkg::inst_t     inst_4_i,
	// Branch resolution
	input  logic                     upd_valid_i,
	input  jump_ctrl_pkg::addr_t     upd_pc_i,
	input  logic                     upd_taken_i,
	input  logic                     upd_mispredict_i,
	input  logic [$clog2(ENTRIES)-1:0] upd_history_i,
	// JALR resolution
	input  logic                     jalr_upd_valid_i,
	input  jump_ctrl_pkg::addr_t     jalr_upd_pc_i,
	input  jump_ctrl_pkg::addr_t     jalr_upd_target_i,
	input  logic                     ras_restore_en_i,
	input  jump_ctrl_pkg::ras_ptr_t  ras_restore_tos_i,
	output logic                     jump_0_o,
	output logic                     jump_1_o,
	output logic                     jump_2_o,
	output logic                     jump_3_o,
	output logic                     jump_4_o,
	output logic                     jalr_0_o,
	output logic                     jalr_1_o,
	output logic                     jalr_2_o,
	output logic                     jalr_3_o,
	output logic                     jalr_4_o,
	output logic [$clog2(ENTRIES)-1:0] global_history_0_o,
	output logic [$clog2(ENTRIES)-1:0] global_history_1_o,
	output logic [$clog2(ENTRIES)-1:0] global_history_2_o,
	output logic [$clog2(ENTRIES)-1:0] global_history_3_o,
	output logic [$clog2(ENTRIES)-1:0] global_history_4_o,
	output logic                     jalr_pred_valid_o,
	output jump_ctrl_pkg::addr_t     jalr_pred_target_o,
	output jump_ctrl_pkg::ras_ptr_t  ras_tos_checkpoint_o
);

	localparam int INDEX_WIDTH = $clog2(ENTRIES);

	jump_ctrl_pkg::slot_vec_t taken_slots;
	jump_ctrl_pkg::slot_vec_t branch_slots; // Already gated by the block chain
	jump_ctrl_pkg::slot_vec_t jalr_slots;
	jump_ctrl_pkg::slot_vec_t call_slots;
	jump_ctrl_pkg::slot_vec_t return_slots;
	jump_ctrl_pkg::addr_t     link_addr_0;
	jump_ctrl_pkg::addr_t     link_addr_1;
	jump_ctrl_pkg::addr_t     link_addr_2;
	jump_ctrl_pkg::addr_t     link_addr_3;
	jump_ctrl_pkg::addr_t     link_addr_4;

	fetch_slot_decoder u_decoder (
		.taken_slots_i  (taken_slots),
		.branch_slots_o (branch_slots),
		.jalr_slots_o   (jalr_slots),
		.call_slots_o   (call_slots),
		.return_slots_o (return_slots),
		.link_addr_0_o  (link_addr_0),
		.link_addr_1_o  (link_addr_1),
		.link_addr_2_o  (link_addr_2),
		.link_addr_3_o  (link_addr_3),
		.link_addr_4_o  (link_addr_4),
		.*
	);

	tournament_predictor #(
		.ENTRIES     (ENTRIES),
		.INDEX_WIDTH (INDEX_WIDTH)
	) u_dir_pred (
		.branch_slots_i (branch_slots),
		.taken_slots_o  (taken_slots),
		.*
	);

	jalr_predictor #(
		.TARGET_ENTRIES (TARGET_ENTRIES)
	) u_jalr_pred (
		.jalr_slots_i   (jalr_slots),
		.call_slots_i   (call_slots),
		.return_slots_i (return_slots),
		.link_addr_0_i  (link_addr_0),
		.link_addr_1_i  (link_addr_1),
		.link_addr_2_i  (link_addr_2),
		.link_addr_3_i  (link_addr_3),
		.link_addr_4_i  (link_addr_4),
		.*
	);

endmodule

`default_nettype wire

// ==== test/jump_controller_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module jump_controller_chk (
	input wire logic       clk,
	input wire logic       rst_n_i,
	input wire logic [4:0] jalr_vec_i,
	input wire logic       jalr_pred_valid_i,
	input wire logic [2:0] ras_tos_checkpoint_i
);

	// At most one redirecting JALR survives the block chain
	a_one_jalr: assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(jalr_vec_i))
		else $error("more than one jalr slot active");

	a_pred_needs_jalr: assert property (@(posedge clk) disable iff (!rst_n_i)
		jalr_pred_valid_i |-> (|jalr_vec_i))
		else $error("jalr prediction valid without a jalr slot");

	a_ras_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> ras_tos_checkpoint_i == 3'd0)
		else $error("RAS pointer not zero after reset");

endmodule

bind jump_controller jump_controller_chk u_chk (
	.clk(clk),
	.rst_n_i(rst_n_i),
	.jalr_vec_i({jalr_4_o, jalr_3_o, jalr_2_o, jalr_1_o, jalr_0_o}),
	.jalr_pred_valid_i(jalr_pred_valid_o),
	.ras_tos_checkpoint_i(ras_tos_checkpoint_o)
);

`default_nettype wire

// ==== test/tb_jump_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_jump_controller;

	localparam int ENTRIES     = 32;
	localparam int IW          = 5; // log2 of ENTRIES
	localparam int CYCLE_LIMIT = 400; // Reset, about 70 directed cycles, 200 random, margin
	localparam logic [31:0] NOP = 32'h0000_0013;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic base_valid;
	logic [31:0] pc_r [5];
	logic [31:0] inst_r [5];
	logic upd_valid, upd_taken, upd_misp, jupd_valid, rs_en;
	logic [31:0] upd_pc, jupd_pc, jupd_tgt;
	logic [IW-1:0] upd_hist;
	logic [2:0] rs_tos;
	wire [4:0] jump_w, jalr_w;
	wire [IW-1:0] hist_w [5];
	wire pv_w;
	wire [31:0] tgt_w;
	wire [2:0] ckpt_w;

	// Mirror of the predictor state
	logic [1:0] bim [ENTRIES];
	logic [1:0] gsh [ENTRIES];
	logic [1:0] cho [ENTRIES];
	logic [IW-1:0] ghr;
	logic [31:0] ras [8];
	logic [2:0] tos;
	logic [15:0] tvld;
	logic [31:0] ttgt [16];

	logic [4:0] m_jmp, m_jlr;
	logic [5:0][IW-1:0] m_h;
	logic m_pv, m_call, m_ret, bok, gok;
	logic [31:0] m_pt, m_push, r, base;
	logic [IW-1:0] bi, gi;
	logic [2:0] cp;
	integer seed = 32'h576c_4d08;
	int errors = 0, checks = 0, tests = 0, test_start = 0, cycles = 0;

	always #2 clk = ~clk;

	jump_controller #(.ENTRIES(ENTRIES), .TARGET_ENTRIES(16)) uut (
		.clk(clk), .rst_n_i(rst_n), .base_valid_i(base_valid),
		.pc_0_i(pc_r[0]), .pc_1_i(pc_r[1]), .pc_2_i(pc_r[2]), .pc_3_i(pc_r[3]), .pc_4_i(pc_r[4]),
		.inst_0_i(inst_r[0]), .inst_1_i(inst_r[1]), .inst_2_i(inst_r[2]),
		.inst_3_i(inst_r[3]), .inst_4_i(inst_r[4]),
		.upd_valid_i(upd_valid), .upd_pc_i(upd_pc), .upd_taken_i(upd_taken),
		.upd_mispredict_i(upd_misp), .upd_history_i(upd_hist),
		.jalr_upd_valid_i(jupd_valid), .jalr_upd_pc_i(jupd_pc), .jalr_upd_target_i(jupd_tgt),
		.ras_restore_en_i(rs_en), .ras_restore_tos_i(rs_tos),
		.jump_0_o(jump_w[0]), .jump_1_o(jump_w[1]), .jump_2_o(jump_w[2]),
		.jump_3_o(jump_w[3]), .jump_4_o(jump_w[4]),
		.jalr_0_o(jalr_w[0]), .jalr_1_o(jalr_w[1]), .jalr_2_o(jalr_w[2]),
		.jalr_3_o(jalr_w[3]), .jalr_4_o(jalr_w[4]),
		.global_history_0_o(hist_w[0]), .global_history_1_o(hist_w[1]),
		.global_history_2_o(hist_w[2]), .global_history_3_o(hist_w[3]),
		.global_history_4_o(hist_w[4]),
		.jalr_pred_valid_o(pv_w), .jalr_pred_target_o(tgt_w), .ras_tos_checkpoint_o(ckpt_w)
	);

	function automatic logic [31:0] enc_jal(input logic [4:0] rd);
		return {20'h00100, rd, jump_ctrl_pkg::OPC_JAL};
	endfunction

	function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		return {12'h000, rs1, 3'b000, rd, jump_ctrl_pkg::OPC_JALR};
	endfunction

	function automatic logic [31:0] enc_br();
		return {7'h00, 5'd2, 5'd3, 3'b000, 5'h08, jump_ctrl_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [4:0] pick_reg(input logic [1:0] s);
		return (s == 2'd0) ? 5'd0 : (s == 2'd1) ? 5'd1 : (s == 2'd2) ? 5'd5 : 5'd6;
	endfunction

	function automatic logic [31:0] rand_inst();
		logic [31:0] v;
		v = $random(seed);
		case (v[2:0])
			3'd0, 3'd1: return NOP;
			3'd2: return enc_jal(pick_reg(v[4:3]));
			3'd3, 3'd4: return enc_br();
			3'd5: return v;
			default: return enc_jalr(pick_reg(v[4:3]), pick_reg(v[6:5]));
		endcase
	endfunction

	function automatic logic [1:0] sat_count(input logic [1:0] c, input logic up);
		if (up)
			return (c == 2'd3) ? c : c + 2'd1;
		return (c == 2'd0) ? c : c - 2'd1;
	endfunction

	//////////////////////////////////////////////////
	// Reference model of one fetch group
	//////////////////////////////////////////////////
	function automatic void model_eval(output logic [4:0] jmp, output logic [4:0] jlr,
			output logic [5:0][IW-1:0] h, output logic pv, output logic [31:0] pt,
			output logic any_call, output logic any_ret, output logic [31:0] push);
		logic act, tk, ret, picked;
		logic [6:0] opc;
		logic [4:0] rd, rs1;
		logic [IW-1:0] ix;
		act = base_valid;
		h[0] = ghr;
		{pv, pt, any_call, any_ret, push, picked} = '0;
		for (int k = 0; k < 5; k++) begin
			opc = inst_r[k][6:0];
			rd = inst_r[k][11:7];
			rs1 = inst_r[k][19:15];
			ix = pc_r[k][IW+1:2];
			tk = cho[ix][1] ? gsh[ix ^ h[k]][1] : bim[ix][1];
			h[k+1] = (act && opc == jump_ctrl_pkg::OPC_BRANCH) ? {h[k][IW-2:0], tk} : h[k];
			jmp[k] = act && (opc == jump_ctrl_pkg::OPC_JAL ||
					(opc == jump_ctrl_pkg::OPC_BRANCH && tk));
			jlr[k] = act && opc == jump_ctrl_pkg::OPC_JALR;
			ret = jlr[k] && (rs1 == 5'd1 || rs1 == 5'd5) && rd == 5'd0;
			if (act && (jmp[k] || jlr[k]) && opc != jump_ctrl_pkg::OPC_BRANCH &&
					(rd == 5'd1 || rd == 5'd5) && !any_call) begin
				any_call = 1'b1;
				push = pc_r[k] + 32'd4;
			end
			any_ret |= ret;
			if (jlr[k] && !picked) begin // First JALR owns the prediction
				picked = 1'b1;
				pv = ret || tvld[pc_r[k][5:2]];
				pt = ret ? ras[tos] : ttgt[pc_r[k][5:2]];
			end
			act = act && !jmp[k] && !jlr[k];
		end
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Compare, then advance the mirror like the next rising edge
	always @(negedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < ENTRIES; i++) begin
				bim[i] = 2'd1;
				gsh[i] = 2'd1;
				cho[i] = 2'd1;
			end
			for (int i = 0; i < 8; i++)
				ras[i] = '0;
			{ghr, tos, tvld} = '0;
		end else begin
			model_eval(m_jmp, m_jlr, m_h, m_pv, m_pt, m_call, m_ret, m_push);
			for (int k = 0; k < 5; k++) begin
				check($sformatf("jump_%0d_o", k), jump_w[k], m_jmp[k]);
				check($sformatf("jalr_%0d_o", k), jalr_w[k], m_jlr[k]);
				check($sformatf("global_history_%0d_o", k), hist_w[k], m_h[k]);
			end
			check("jalr_pred_valid_o", pv_w, m_pv);
			if (m_pv)
				check("jalr_pred_target_o", tgt_w, m_pt);
			check("ras_tos_checkpoint_o", ckpt_w, tos);
			if (upd_valid) begin
				bi = upd_pc[IW+1:2];
				gi = bi ^ upd_hist;
				bok = bim[bi][1] == upd_taken;
				gok = gsh[gi][1] == upd_taken;
				bim[bi] = sat_count(bim[bi], upd_taken);
				gsh[gi] = sat_count(gsh[gi], upd_taken);
				if (bok != gok)
					cho[bi] = sat_count(cho[bi], gok);
			end
			if (upd_valid && upd_misp)
				ghr = {upd_hist[IW-2:0], upd_taken};
			else if (base_valid)
				ghr = m_h[5];
			if (rs_en) begin
				tos = rs_tos;
			end else if (base_valid && m_ret) begin
				tos = tos - 3'd1;
			end else if (base_valid && m_call) begin
				tos = tos + 3'd1;
				ras[tos] = m_push;
			end
			if (jupd_valid) begin
				tvld[jupd_pc[5:2]] = 1'b1;
				ttgt[jupd_pc[5:2]] = jupd_tgt;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// New group, all update strobes dropped
	task automatic fetch(input logic v, input logic [31:0] b, input logic [31:0] i0,
			input logic [31:0] i1, input logic [31:0] i2, input logic [31:0] i3,
			input logic [31:0] i4);
		@(posedge clk);
		base_valid <= v;
		for (int k = 0; k < 5; k++)
			pc_r[k] <= b + 32'(4 * k);
		inst_r[0] <= i0;
		inst_r[1] <= i1;
		inst_r[2] <= i2;
		inst_r[3] <= i3;
		inst_r[4] <= i4;
		{upd_valid, jupd_valid, rs_en} <= 3'b000;
	endtask

	task automatic branch_update(input logic [31:0] p, input logic t, input logic m,
			input logic [IW-1:0] h);
		upd_valid <= 1'b1;
		upd_pc <= p;
		upd_taken <= t;
		upd_misp <= m;
		upd_hist <= h;
	endtask

	task automatic jalr_update(input logic [31:0] p, input logic [31:0] t);
		jupd_valid <= 1'b1;
		jupd_pc <= p;
		jupd_tgt <= t;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("Test %s done with %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	initial begin
		base_valid = 1'b0;
		for (int k = 0; k < 5; k++) begin
			pc_r[k] = '0;
			inst_r[k] = NOP;
		end
		{upd_valid, upd_taken, upd_misp, jupd_valid, rs_en} = '0;
		{upd_pc, jupd_pc, jupd_tgt, upd_hist, rs_tos} = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		repeat (30)
			fetch(($random(seed) & 3) != 0, $random(seed) & 32'h0000_0ffc,
					rand_inst(), rand_inst(), rand_inst(), rand_inst(), rand_inst());
		finish_test("decode");

		fetch(1'b1, 32'h100, enc_br(), NOP, NOP, NOP, NOP);
		@(negedge clk) check("jump_0_o", jump_w[0], 1'b0);
		repeat (3) begin
			fetch(1'b0, 32'h0, NOP, NOP, NOP, NOP, NOP);
			branch_update(32'h100, 1'b1, 1'b0, '0);
		end
		fetch(1'b1, 32'h100, enc_br(), NOP, NOP, NOP, NOP);
		@(negedge clk) check("jump_0_o", jump_w[0], 1'b1);
		fetch(1'b0, 32'h0, NOP, NOP, NOP, NOP, NOP);
		branch_update(32'h100, 1'b0, 1'b1, 5'h03); // Bimodal wrong and gshare right
		fetch(1'b1, 32'h100, enc_br(), NOP, NOP, NOP, NOP);
		@(negedge clk) check("jump_0_o", jump_w[0], 1'b0); // Chooser now on gshare
		finish_test("training");

		fetch(1'b1, 32'hf4, enc_br(), enc_br(), enc_br(), enc_br(), NOP);
		@(negedge clk) check("jump_3_o", jump_w[3], 1'b1);
		fetch(1'b0, 32'h0, NOP, NOP, NOP, NOP, NOP);
		branch_update(32'h100, 1'b0, 1'b1, 5'h0a);
		fetch(1'b1, 32'hf4, enc_br(), enc_br(), enc_br(), enc_br(), NOP);
		@(negedge clk) check("global_history_0_o", hist_w[0], 5'h14);
		finish_test("history");

		for (int i = 4; i <= 6; i++)
			fetch(1'b1, 32'(i) << 8, enc_jal(5'd1), NOP, NOP, NOP, NOP);
		for (int i = 6; i >= 4; i--) begin
			fetch(1'b1, 32'h700, enc_jalr(5'd0, 5'd1), NOP, NOP, NOP, NOP);
			@(negedge clk) check("jalr_pred_target_o", tgt_w, (32'(i) << 8) + 32'd4);
		end
		fetch(1'b1, 32'h400, enc_jal(5'd5), NOP, NOP, NOP, NOP);
		fetch(1'b1, 32'h800, enc_jal(5'd1), NOP, NOP, NOP, NOP);
		@(negedge clk) cp = ckpt_w; // Top holds 0x404 here
		fetch(1'b1, 32'h900, enc_jalr(5'd1, 5'd6), NOP, NOP, NOP, NOP);
		fetch(1'b0, 32'h0, NOP, NOP, NOP, NOP, NOP);
		rs_en <= 1'b1;
		rs_tos <= cp;
		fetch(1'b1, 32'h700, NOP, enc_jalr(5'd0, 5'd5), NOP, NOP, NOP);
		@(negedge clk) check("jalr_pred_target_o", tgt_w, 32'h404);
		finish_test("ras");

		fetch(1'b1, 32'h200, enc_jalr(5'd0, 5'd6), NOP, NOP, NOP, NOP);
		@(negedge clk) check("jalr_pred_valid_o", pv_w, 1'b0);
		fetch(1'b0, 32'h0, NOP, NOP, NOP, NOP, NOP);
		jalr_update(32'h200, 32'h1234);
		fetch(1'b1, 32'h200, enc_jalr(5'd0, 5'd6), NOP, NOP, NOP, NOP);
		@(negedge clk) check("jalr_pred_target_o", tgt_w, 32'h1234);
		fetch(1'b0, 32'h0, NOP, NOP, NOP, NOP, NOP);
		jalr_update(32'h240, 32'h5678);
		fetch(1'b1, 32'h200, enc_jalr(5'd0, 5'd6), NOP, NOP, NOP, NOP);
		@(negedge clk) check("jalr_pred_target_o", tgt_w, 32'h5678);
		finish_test("target cache");

		repeat (200) begin
			base = $random(seed) & 32'h0000_0ffc;
			fetch(($random(seed) & 3) != 0, base,
					rand_inst(), rand_inst(), rand_inst(), rand_inst(), rand_inst());
			r = $random(seed);
			if (r[0])
				branch_update($random(seed) & 32'h0000_0ffc, r[1], r[2], r[7:3]);
			if (r[8])
				jalr_update($random(seed) & 32'h0000_0ffc, $random(seed));
			if (r[12:9] == 4'd0) begin
				rs_en <= 1'b1;
				rs_tos <= r[15:13];
			end
		end
		@(negedge clk);
		finish_test("random mix");

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
hw/jump_ctrl_pkg.sv
hw/fetch_slot_decoder.sv
hw/tournament_predictor.sv
hw/jalr_predictor.sv
hw/jump_controller.sv
test/jump_controller_chk.sv
test/tb_jump_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the jump controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_jump_controller \
	-o sim_tb_jump_controller
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_jump_controller > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
	exit 1
fi
exit 0
